/* logic/ip_tx_pkg.sv */
//**********************************************************
// shared types for the IPv4 transmit framer: field widths,
// header structs, stream beat, FSM states and constants
//**********************************************************

package ip_tx_pkg;

    // field widths
    typedef logic [7:0]  byte_t;
    typedef logic [47:0] eth_mac_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] word16_t;

    // byte index within the fixed 20-byte header
    typedef logic [4:0]  hdr_idx_t;

    // ethernet header, passed through untouched
    typedef struct packed {
        eth_mac_t dest_mac;
        eth_mac_t src_mac;
        word16_t  eth_type;
    } eth_hdr_t;

    // ipv4 fields supplied by the user
    // version, ihl and checksum are generated here
    typedef struct packed {
        logic [5:0]  dscp;
        logic [1:0]  ecn;
        word16_t     length;
        word16_t     identification;
        logic [2:0]  flags;
        logic [12:0] fragment_offset;
        byte_t       ttl;
        byte_t       protocol;
        ip_addr_t    source_ip;
        ip_addr_t    dest_ip;
    } ip_hdr_t;

    // one byte of a stream
    typedef struct packed {
        byte_t data;
        logic  last;
        logic  user;
    } axis_beat_t;

    typedef enum logic [1:0] {
        st_idle,
        st_write_header,
        st_write_payload,
        st_write_payload_last
    } framer_state_t;

    // no options, so ihl is fixed
    localparam logic [3:0]  IP_VERSION   = 4'd4;
    localparam logic [3:0]  IP_IHL       = 4'd5;
    localparam int unsigned IP_HDR_BYTES = 20;

endpackage

/* logic/ip_hdr_checksum.sv */
//**********************************************************
// registered one's-complement sum over an IPv4 header
//**********************************************************

`timescale 1ns/100ps

module ip_hdr_checksum (
    input  logic                clk,
    input  ip_tx_pkg::ip_hdr_t  hdr,
    output ip_tx_pkg::word16_t  checksum
);
    import ip_tx_pkg::*;

    word16_t     words [10];
    logic [19:0] acc;
    logic [16:0] fold;
    word16_t     sum;

    // the ten header words in network order
    always_comb begin
        words[0] = {IP_VERSION, IP_IHL, hdr.dscp, hdr.ecn};
        words[1] = hdr.length;
        words[2] = hdr.identification;
        words[3] = {hdr.flags, hdr.fragment_offset};
        words[4] = {hdr.ttl, hdr.protocol};
        // checksum field counts as zero
        words[5] = 16'h0000;
        words[6] = hdr.source_ip[31:16];
        words[7] = hdr.source_ip[15:0];
        words[8] = hdr.dest_ip[31:16];
        words[9] = hdr.dest_ip[15:0];
    end

    // wide add, then fold carries back in twice
    always_comb begin
        acc = '0;
        for (int i = 0; i < 10; i++) begin
            acc = acc + 20'(words[i]);
        end
        fold = 17'(acc[15:0]) + 17'(acc[19:16]);
        sum = fold[15:0] + 16'(fold[16]);
    end

    // inversion happens in the framer
    always_ff @(posedge clk) begin
        checksum <= sum;
    end

endmodule

/* logic/ip_tx_framer.sv */
//**********************************************************
// IPv4 header capture, header byte sequencer and
// payload length tracking with early end detection
//**********************************************************

`timescale 1ns/100ps

module ip_tx_framer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  s_ip_hdr_valid,
    output logic                  s_ip_hdr_ready,
    input  ip_tx_pkg::eth_hdr_t   s_eth_hdr,
    input  ip_tx_pkg::ip_hdr_t    s_ip_hdr,
    input  ip_tx_pkg::axis_beat_t s_payload,
    input  logic                  s_payload_valid,
    output logic                  s_payload_ready,
    output logic                  m_eth_hdr_valid,
    input  logic                  m_eth_hdr_ready,
    output ip_tx_pkg::eth_hdr_t   m_eth_hdr,
    output ip_tx_pkg::ip_hdr_t    stored_ip_hdr,
    input  ip_tx_pkg::word16_t    checksum,
    output ip_tx_pkg::axis_beat_t beat,
    output logic                  beat_valid,
    input  logic                  ready_early,
    output logic                  busy,
    output logic                  error_payload_early_termination
);
    import ip_tx_pkg::*;

    localparam hdr_idx_t LAST_HDR_IDX = hdr_idx_t'(IP_HDR_BYTES - 1);

    framer_state_t state_reg, state_next;
    hdr_idx_t      hdr_idx_reg, hdr_idx_next;
    word16_t       count_reg, count_next;
    byte_t         hdr_byte;
    byte_t         last_byte_reg;
    eth_hdr_t      eth_hdr_reg;
    ip_hdr_t       ip_hdr_reg;

    logic store_hdr, store_last;
    logic hdr_ready_reg, hdr_ready_next;
    logic payload_ready_reg, payload_ready_next;
    logic eth_valid_reg, eth_valid_next;
    logic out_ready_reg;
    logic busy_reg;
    logic error_reg, error_next;
    logic payload_xfer;

    assign s_ip_hdr_ready                  = hdr_ready_reg;
    assign s_payload_ready                 = payload_ready_reg;
    assign m_eth_hdr_valid                 = eth_valid_reg;
    assign m_eth_hdr                       = eth_hdr_reg;
    assign stored_ip_hdr                   = ip_hdr_reg;
    assign busy                            = busy_reg;
    assign error_payload_early_termination = error_reg;

    assign payload_xfer = s_payload_valid && payload_ready_reg;

    // header bytes in network order, index held at 0 outside the header
    always_comb begin
        case (hdr_idx_reg)
            5'd0:    hdr_byte = {IP_VERSION, IP_IHL};
            5'd1:    hdr_byte = {ip_hdr_reg.dscp, ip_hdr_reg.ecn};
            5'd2:    hdr_byte = ip_hdr_reg.length[15:8];
            5'd3:    hdr_byte = ip_hdr_reg.length[7:0];
            5'd4:    hdr_byte = ip_hdr_reg.identification[15:8];
            5'd5:    hdr_byte = ip_hdr_reg.identification[7:0];
            5'd6:    hdr_byte = {ip_hdr_reg.flags, ip_hdr_reg.fragment_offset[12:8]};
            5'd7:    hdr_byte = ip_hdr_reg.fragment_offset[7:0];
            5'd8:    hdr_byte = ip_hdr_reg.ttl;
            5'd9:    hdr_byte = ip_hdr_reg.protocol;
            5'd10:   hdr_byte = ~checksum[15:8];
            5'd11:   hdr_byte = ~checksum[7:0];
            5'd12:   hdr_byte = ip_hdr_reg.source_ip[31:24];
            5'd13:   hdr_byte = ip_hdr_reg.source_ip[23:16];
            5'd14:   hdr_byte = ip_hdr_reg.source_ip[15:8];
            5'd15:   hdr_byte = ip_hdr_reg.source_ip[7:0];
            5'd16:   hdr_byte = ip_hdr_reg.dest_ip[31:24];
            5'd17:   hdr_byte = ip_hdr_reg.dest_ip[23:16];
            5'd18:   hdr_byte = ip_hdr_reg.dest_ip[15:8];
            5'd19:   hdr_byte = ip_hdr_reg.dest_ip[7:0];
            default: hdr_byte = '0;
        endcase
    end

    always_comb begin
        state_next         = state_reg;
        hdr_idx_next       = hdr_idx_reg;
        count_next         = count_reg;
        store_hdr          = 1'b0;
        store_last         = 1'b0;
        hdr_ready_next     = 1'b0;
        payload_ready_next = 1'b0;
        eth_valid_next     = eth_valid_reg && !m_eth_hdr_ready;
        error_next         = 1'b0;
        beat               = '0;
        beat_valid         = 1'b0;

        case (state_reg)
            st_idle: begin
                hdr_idx_next   = '0;
                hdr_ready_next = !eth_valid_next;
                if (s_ip_hdr_valid && hdr_ready_reg) begin
                    store_hdr      = 1'b1;
                    hdr_ready_next = 1'b0;
                    eth_valid_next = 1'b1;
                    state_next     = st_write_header;
                    // first byte is constant, send it right away
                    if (out_ready_reg) begin
                        beat.data    = hdr_byte;
                        beat_valid   = 1'b1;
                        hdr_idx_next = 5'd1;
                    end
                end
            end
            st_write_header: begin
                count_next = ip_hdr_reg.length - word16_t'(IP_HDR_BYTES);
                if (out_ready_reg) begin
                    beat.data    = hdr_byte;
                    beat_valid   = 1'b1;
                    hdr_idx_next = hdr_idx_reg + 5'd1;
                    if (hdr_idx_reg == LAST_HDR_IDX) begin
                        hdr_idx_next       = '0;
                        payload_ready_next = ready_early;
                        state_next         = st_write_payload;
                    end
                end
            end
            st_write_payload: begin
                payload_ready_next = ready_early;
                beat               = s_payload;
                beat_valid         = payload_xfer;
                if (payload_xfer) begin
                    count_next = count_reg - 16'd1;
                    if (s_payload.last) begin
                        // input ended short of the stated length
                        if (count_reg != 16'd1) begin
                            beat.user  = 1'b1;
                            error_next = 1'b1;
                        end
                        hdr_ready_next     = !eth_valid_next;
                        payload_ready_next = 1'b0;
                        state_next         = st_idle;
                    end else if (count_reg == 16'd1) begin
                        // hold final byte until the input frame ends
                        store_last = 1'b1;
                        beat_valid = 1'b0;
                        state_next = st_write_payload_last;
                    end
                end
            end
            st_write_payload_last: begin
                payload_ready_next = ready_early;
                beat.data          = last_byte_reg;
                beat.last          = s_payload.last;
                beat.user          = s_payload.user;
                beat_valid         = payload_xfer && s_payload.last;
                // extra bytes are dropped
                if (payload_xfer && s_payload.last) begin
                    hdr_ready_next     = !eth_valid_next;
                    payload_ready_next = 1'b0;
                    state_next         = st_idle;
                end
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg         <= st_idle;
            hdr_idx_reg       <= '0;
            hdr_ready_reg     <= 1'b0;
            payload_ready_reg <= 1'b0;
            eth_valid_reg     <= 1'b0;
            out_ready_reg     <= 1'b0;
            busy_reg          <= 1'b0;
            error_reg         <= 1'b0;
        end else begin
            state_reg         <= state_next;
            hdr_idx_reg       <= hdr_idx_next;
            hdr_ready_reg     <= hdr_ready_next;
            payload_ready_reg <= payload_ready_next;
            eth_valid_reg     <= eth_valid_next;
            out_ready_reg     <= ready_early;
            busy_reg          <= state_next != st_idle;
            error_reg         <= error_next;
        end

        count_reg <= count_next;
        if (store_hdr) begin
            eth_hdr_reg <= s_eth_hdr;
            ip_hdr_reg  <= s_ip_hdr;
        end
        if (store_last) begin
            last_byte_reg <= s_payload.data;
        end
    end

    // payload side stays closed between frames
    a_no_payload_ready_idle: assert property (@(posedge clk) disable iff (rst)
        state_reg == st_idle |-> !payload_ready_reg)
        else $error("payload ready high while idle");

    a_hdr_idx_range: assert property (@(posedge clk) disable iff (rst)
        hdr_idx_reg <= LAST_HDR_IDX)
        else $error("header byte index out of range");

endmodule

/* logic/axis_out_buffer.sv */
//**********************************************************
// two-entry output stage with early ready for the framer
//**********************************************************

`timescale 1ns/100ps

module axis_out_buffer (
    input  logic                  clk,
    input  logic                  rst,
    input  ip_tx_pkg::axis_beat_t in_beat,
    input  logic                  in_valid,
    output logic                  ready_early,
    output ip_tx_pkg::axis_beat_t out_beat,
    output logic                  out_valid,
    input  logic                  out_ready
);
    import ip_tx_pkg::*;

    axis_beat_t out_reg, spare_reg;
    logic       out_valid_reg, out_valid_next;
    logic       spare_valid_reg, spare_valid_next;
    logic       load_out_from_in, load_out_from_spare, load_spare;

    assign out_beat  = out_reg;
    assign out_valid = out_valid_reg;

    // next cycle can take a beat unless the spare would be needed and is full
    assign ready_early = out_ready || (!spare_valid_reg && (!out_valid_reg || !in_valid));

    always_comb begin
        out_valid_next      = out_valid_reg;
        spare_valid_next    = spare_valid_reg;
        load_out_from_in    = 1'b0;
        load_out_from_spare = 1'b0;
        load_spare          = 1'b0;

        if (in_valid) begin
            if (out_ready || !out_valid_reg) begin
                out_valid_next   = 1'b1;
                load_out_from_in = 1'b1;
            end else begin
                // output stalled, park in spare
                spare_valid_next = 1'b1;
                load_spare       = 1'b1;
            end
        end else if (out_ready) begin
            out_valid_next      = spare_valid_reg;
            spare_valid_next    = 1'b0;
            load_out_from_spare = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_reg   <= 1'b0;
            spare_valid_reg <= 1'b0;
        end else begin
            out_valid_reg   <= out_valid_next;
            spare_valid_reg <= spare_valid_next;
        end

        if (load_out_from_in) begin
            out_reg <= in_beat;
        end else if (load_out_from_spare) begin
            out_reg <= spare_reg;
        end
        if (load_spare) begin
            spare_reg <= in_beat;
        end
    end

    a_out_stable: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_beat))
        else $error("output beat changed while stalled");

    // the framer only sends on its registered copy of ready_early
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        in_valid |-> !spare_valid_reg)
        else $error("beat offered with spare entry full");

endmodule

/* logic/ip_eth_tx.sv */
//**********************************************************
// IPv4 transmit top: framer, checksum and output buffer
//**********************************************************

`timescale 1ns/100ps

module ip_eth_tx (
    input  logic                  clk,
    input  logic                  rst,

    // header and payload in
    input  logic                  s_ip_hdr_valid,
    output logic                  s_ip_hdr_ready,
    input  ip_tx_pkg::eth_hdr_t   s_eth_hdr,
    input  ip_tx_pkg::ip_hdr_t    s_ip_hdr,
    input  ip_tx_pkg::axis_beat_t s_payload,
    input  logic                  s_payload_valid,
    output logic                  s_payload_ready,

    // ethernet header and payload out
    output logic                  m_eth_hdr_valid,
    input  logic                  m_eth_hdr_ready,
    output ip_tx_pkg::eth_hdr_t   m_eth_hdr,
    output ip_tx_pkg::axis_beat_t m_payload,
    output logic                  m_payload_valid,
    input  logic                  m_payload_ready,

    output logic                  busy,
    output logic                  error_payload_early_termination
);
    import ip_tx_pkg::*;

    ip_hdr_t    stored_ip_hdr;
    word16_t    checksum;
    axis_beat_t beat;
    logic       beat_valid;
    logic       ready_early;

    ip_tx_framer u_framer (
        .clk                             (clk),
        .rst                             (rst),
        .s_ip_hdr_valid                  (s_ip_hdr_valid),
        .s_ip_hdr_ready                  (s_ip_hdr_ready),
        .s_eth_hdr                       (s_eth_hdr),
        .s_ip_hdr                        (s_ip_hdr),
        .s_payload                       (s_payload),
        .s_payload_valid                 (s_payload_valid),
        .s_payload_ready                 (s_payload_ready),
        .m_eth_hdr_valid                 (m_eth_hdr_valid),
        .m_eth_hdr_ready                 (m_eth_hdr_ready),
        .m_eth_hdr                       (m_eth_hdr),
        .stored_ip_hdr                   (stored_ip_hdr),
        .checksum                        (checksum),
        .beat                            (beat),
        .beat_valid                      (beat_valid),
        .ready_early                     (ready_early),
        .busy                            (busy),
        .error_payload_early_termination (error_payload_early_termination)
    );

    // sum is ready long before byte 10 goes out
    ip_hdr_checksum u_checksum (
        .clk      (clk),
        .hdr      (stored_ip_hdr),
        .checksum (checksum)
    );

    axis_out_buffer u_out_buffer (
        .clk         (clk),
        .rst         (rst),
        .in_beat     (beat),
        .in_valid    (beat_valid),
        .ready_early (ready_early),
        .out_beat    (m_payload),
        .out_valid   (m_payload_valid),
        .out_ready   (m_payload_ready)
    );

endmodule

/* tests/ip_tx_tb_util.svh */
//**********************************************************
// reference model: IPv4 header bytes, checksum rule and
// expected output stream of one frame
//**********************************************************

`ifndef IP_TX_TB_UTIL_SVH
`define IP_TX_TB_UTIL_SVH

// all 20 header bytes in network order, first byte on top
function automatic logic [159:0] hdr_bits(input ip_hdr_t h, input word16_t csum);
    return {4'h4, 4'h5, h.dscp, h.ecn, h.length, h.identification,
            h.flags, h.fragment_offset, h.ttl, h.protocol, csum,
            h.source_ip, h.dest_ip};
endfunction

// one's-complement sum of the ten words, checksum field at zero
function automatic word16_t ref_checksum(input ip_hdr_t h);
    logic [159:0] v;
    logic [31:0]  s;
    v = hdr_bits(h, 16'h0000);
    s = '0;
    for (int i = 0; i < 10; i++) begin
        s = s + {16'h0000, v[159 - 16*i -: 16]};
    end
    // end-around carry until nothing is left above bit 15
    while (s[31:16] != 16'h0000) begin
        s = {16'h0000, s[15:0]} + {16'h0000, s[31:16]};
    end
    return ~s[15:0];
endfunction

// append the expected output for the header and the frame in pay_q
function automatic void build_expected(input ip_hdr_t h);
    logic [159:0] v;
    axis_beat_t   b;
    int           want;
    int           keep;
    v = hdr_bits(h, ref_checksum(h));
    for (int i = 0; i < 20; i++) begin
        b = '0;
        b.data = v[159 - 8*i -: 8];
        exp_q.push_back(b);
    end
    want = int'(h.length) - 20;
    keep = (pay_q.size() < want) ? pay_q.size() : want;
    for (int i = 0; i < keep; i++) begin
        b = '0;
        b.data = pay_q[i].data;
        exp_q.push_back(b);
    end
    // final byte closes the frame, user marks a short one
    b = exp_q.pop_back();
    b.last = 1'b1;
    b.user = (keep < want) ? 1'b1 : pay_q[pay_q.size() - 1].user;
    exp_q.push_back(b);
endfunction

`endif

/* tests/tb_ip_eth_tx.sv */
//**********************************************************
// testbench for the IPv4 transmit framer: clock, reset,
// directed tests and summary
//**********************************************************

`timescale 1ns/100ps

module tb_ip_eth_tx;
    import ip_tx_pkg::*;

    localparam int TIMEOUT = 2000;

    logic       clk;
    logic       rst;
    logic       s_ip_hdr_valid;
    logic       s_ip_hdr_ready;
    eth_hdr_t   s_eth_hdr;
    ip_hdr_t    s_ip_hdr;
    axis_beat_t s_payload;
    logic       s_payload_valid;
    logic       s_payload_ready;
    logic       m_eth_hdr_valid;
    logic       m_eth_hdr_ready;
    eth_hdr_t   m_eth_hdr;
    axis_beat_t m_payload;
    logic       m_payload_valid;
    logic       m_payload_ready;
    logic       busy;
    logic       error_payload_early_termination;

    // current frame, expectations and captured output
    eth_hdr_t   cur_eth;
    ip_hdr_t    cur_ip;
    axis_beat_t pay_q[$];
    axis_beat_t exp_q[$];
    axis_beat_t got_q[$];
    eth_hdr_t   exp_eth_q[$];
    eth_hdr_t   got_eth_q[$];
    int         err_pulses;
    int         test_errors;
    int         total_errors;
    int         tests_run;
    int         tests_failed;

    // random ready pattern for downstream back-pressure
    logic          bp_en;
    logic [1023:0] bp_bits;
    logic [9:0]    bp_idx;

    `include "ip_tx_tb_util.svh"

    ip_eth_tx UUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        m_payload_ready = 1'b1;
        bp_idx = '0;
        forever begin
            @(posedge clk);
            m_payload_ready <= bp_en ? bp_bits[bp_idx] : 1'b1;
            bp_idx <= bp_idx + 10'd1;
        end
    end

    // outputs are stable at the falling edge, transfer follows at the next rise
    always @(negedge clk) begin
        if (!rst) begin
            if (m_payload_valid && m_payload_ready) begin
                got_q.push_back(m_payload);
            end
            if (m_eth_hdr_valid && m_eth_hdr_ready) begin
                got_eth_q.push_back(m_eth_hdr);
            end
            if (error_payload_early_termination) begin
                err_pulses++;
            end
        end
    end

    function automatic int count_lasts();
        int c;
        c = 0;
        foreach (got_q[i]) begin
            if (got_q[i].last) begin
                c++;
            end
        end
        return c;
    endfunction

    // random headers and payload, expectation appended
    function automatic void make_frame(input int n_pay, input int n_len, input logic last_user);
        axis_beat_t b;
        cur_eth = eth_hdr_t'(112'({$urandom(), $urandom(), $urandom(), $urandom()}));
        cur_ip = ip_hdr_t'(136'({$urandom(), $urandom(), $urandom(), $urandom(), $urandom()}));
        cur_ip.length = word16_t'(20 + n_len);
        pay_q.delete();
        for (int i = 0; i < n_pay; i++) begin
            b.data = 8'($urandom());
            b.last = (i == n_pay - 1);
            b.user = (i == n_pay - 1) ? last_user : 1'b0;
            pay_q.push_back(b);
        end
        exp_eth_q.push_back(cur_eth);
        build_expected(cur_ip);
    endfunction

    task automatic drive_header();
        s_eth_hdr      <= cur_eth;
        s_ip_hdr       <= cur_ip;
        s_ip_hdr_valid <= 1'b1;
    endtask

    task automatic wait_hdr_accept();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!s_ip_hdr_ready && n < TIMEOUT);
        s_ip_hdr_valid <= 1'b0;
        assert (s_ip_hdr_ready) else begin
            $display("IP header was not accepted before the timeout");
            test_errors++;
        end
    endtask

    task automatic send_payload();
        int   n;
        logic ok;
        ok = 1'b1;
        for (int i = 0; i < pay_q.size() && ok; i++) begin
            s_payload       <= pay_q[i];
            s_payload_valid <= 1'b1;
            n = 0;
            do begin
                @(posedge clk);
                n++;
            end while (!s_payload_ready && n < TIMEOUT);
            ok = s_payload_ready;
        end
        s_payload_valid <= 1'b0;
        assert (ok) else begin
            $display("payload beat was not accepted before the timeout");
            test_errors++;
        end
    endtask

    task automatic run_frame(input int n_pay, input int n_len, input logic last_user);
        make_frame(n_pay, n_len, last_user);
        drive_header();
        wait_hdr_accept();
        send_payload();
    endtask

    // until the frame ends reach the output and the framer is idle
    task automatic wait_frames(input int frames);
        int n;
        n = 0;
        while ((count_lasts() < frames || busy) && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        assert (count_lasts() >= frames && !busy) else begin
            $display("frame end did not reach the output before the timeout");
            test_errors++;
        end
    endtask

    task automatic check_outputs(input int exp_err);
        assert (got_q.size() == exp_q.size()) else begin
            $display("Mismatch m_payload beat count: got %h expected %h",
                     got_q.size(), exp_q.size());
            test_errors++;
        end
        foreach (exp_q[i]) begin
            if (i < got_q.size()) begin
                assert (got_q[i] == exp_q[i]) else begin
                    $display("Mismatch m_payload beat %0d: got %h/%h/%h expected %h/%h/%h",
                             i, got_q[i].data, got_q[i].last, got_q[i].user,
                             exp_q[i].data, exp_q[i].last, exp_q[i].user);
                    test_errors++;
                end
            end
        end
        assert (got_eth_q.size() == exp_eth_q.size()) else begin
            $display("Mismatch m_eth_hdr count: got %h expected %h",
                     got_eth_q.size(), exp_eth_q.size());
            test_errors++;
        end
        foreach (exp_eth_q[i]) begin
            if (i < got_eth_q.size()) begin
                assert (got_eth_q[i] == exp_eth_q[i]) else begin
                    $display("Mismatch m_eth_hdr %0d: got %h expected %h",
                             i, got_eth_q[i], exp_eth_q[i]);
                    test_errors++;
                end
            end
        end
        assert (err_pulses == exp_err) else begin
            $display("Mismatch error_payload_early_termination cycles: got %h expected %h",
                     err_pulses, exp_err);
            test_errors++;
        end
    endtask

    task automatic start_test();
        got_q.delete();
        exp_q.delete();
        got_eth_q.delete();
        exp_eth_q.delete();
        err_pulses = 0;
        test_errors = 0;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        total_errors += test_errors;
        if (test_errors == 0) begin
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, test_errors);
        end
    endtask

    task automatic test_matching_payload();
        start_test();
        run_frame(12, 12, 1'b0);
        wait_frames(1);
        check_outputs(0);
        end_test("matching payload");
    endtask

    task automatic test_short_payload();
        start_test();
        run_frame(5, 12, 1'b0);
        wait_frames(1);
        check_outputs(1);
        end_test("short payload");
    endtask

    task automatic test_long_payload();
        start_test();
        // user on the input's last beat has to reach the output
        run_frame(15, 10, 1'b1);
        wait_frames(1);
        check_outputs(0);
        end_test("long payload");
    endtask

    task automatic test_backpressure();
        start_test();
        bp_en <= 1'b1;
        run_frame(30, 30, 1'b0);
        wait_frames(1);
        bp_en <= 1'b0;
        check_outputs(0);
        end_test("payload back-pressure");
    endtask

    task automatic test_header_backpressure();
        start_test();
        m_eth_hdr_ready <= 1'b0;
        run_frame(8, 8, 1'b0);
        make_frame(6, 6, 1'b0);
        drive_header();
        // second offer must wait while the first Ethernet header is pending
        for (int i = 0; i < 20; i++) begin
            @(posedge clk);
            assert (m_eth_hdr_valid && !s_ip_hdr_ready) else begin
                $display("second header taken while the first Ethernet header was pending");
                test_errors++;
            end
        end
        m_eth_hdr_ready <= 1'b1;
        wait_hdr_accept();
        send_payload();
        wait_frames(2);
        check_outputs(0);
        end_test("header back-pressure");
    endtask

    task automatic test_busy_and_reset();
        logic [5:0] ctrl;
        start_test();
        rst <= 1'b1;
        repeat (5) @(posedge clk);
        ctrl = {s_ip_hdr_ready, s_payload_ready, m_eth_hdr_valid,
                m_payload_valid, busy, error_payload_early_termination};
        assert (ctrl == 6'h00) else begin
            $display("Mismatch control outputs in reset: got %h expected %h", ctrl, 6'h00);
            test_errors++;
        end
        rst <= 1'b0;
        @(posedge clk);
        assert (!s_ip_hdr_ready) else begin
            $display("Mismatch s_ip_hdr_ready at reset release: got %h expected %h",
                     s_ip_hdr_ready, 1'b0);
            test_errors++;
        end
        @(posedge clk);
        assert (s_ip_hdr_ready) else begin
            $display("Mismatch s_ip_hdr_ready after reset: got %h expected %h",
                     s_ip_hdr_ready, 1'b1);
            test_errors++;
        end
        make_frame(10, 10, 1'b0);
        drive_header();
        wait_hdr_accept();
        @(posedge clk);
        assert (busy) else begin
            $display("Mismatch busy after header: got %h expected %h", busy, 1'b1);
            test_errors++;
        end
        send_payload();
        assert (busy) else begin
            $display("Mismatch busy at last input beat: got %h expected %h", busy, 1'b1);
            test_errors++;
        end
        @(posedge clk);
        assert (!busy) else begin
            $display("Mismatch busy after last input beat: got %h expected %h", busy, 1'b0);
            test_errors++;
        end
        wait_frames(1);
        check_outputs(0);
        end_test("busy and reset state");
    endtask

    initial begin
        void'($urandom(53872));
        rst             = 1'b1;
        s_ip_hdr_valid  = 1'b0;
        s_eth_hdr       = '0;
        s_ip_hdr        = '0;
        s_payload       = '0;
        s_payload_valid = 1'b0;
        m_eth_hdr_ready = 1'b1;
        bp_en           = 1'b0;
        err_pulses      = 0;
        test_errors     = 0;
        total_errors    = 0;
        tests_run       = 0;
        tests_failed    = 0;
        for (int i = 0; i < 32; i++) begin
            bp_bits[32*i +: 32] = $urandom();
        end

        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        test_matching_payload();
        test_short_payload();
        test_long_payload();
        test_backpressure();
        test_header_backpressure();
        test_busy_and_reset();

        $display("%0d tests run, %0d failing, %0d check errors",
                 tests_run, tests_failed, total_errors);
        if (tests_failed == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+tests
logic/ip_tx_pkg.sv
logic/ip_hdr_checksum.sv
logic/ip_tx_framer.sv
logic/axis_out_buffer.sv
logic/ip_eth_tx.sv
tests/tb_ip_eth_tx.sv

/* run_sim.sh */
#!/bin/sh
# build the IPv4 framer testbench with Verilator, run it and look for the pass line
verilator --binary --assert --top-module tb_ip_eth_tx -f filelist.f \
    && ./obj_dir/Vtb_ip_eth_tx | tee /dev/stderr | grep -qx "Test completed successfully" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
